// ==== sandboxPkg.sv ====
// sandbox shared definitions: table geometry, payload types, request field layout

package sandboxPkg;

  // ------------------------------------------------------------------------
  // host link widths
  // ------------------------------------------------------------------------
  localparam int ctrlWidth   = 8;               // control byte
  localparam int dataWidth   = 32;              // request / reply data word
  localparam int statusWidth = 8;               // reply status byte

  // ------------------------------------------------------------------------
  // table geometry
  // ------------------------------------------------------------------------
  localparam int tableDepth = 16;               // entries per table
  localparam int indexWidth = $clog2(tableDepth);   // index bits used from byte 0

  // payloads held by the two tables
  typedef logic [7:0] valueT;                   // value table byte
  typedef logic [7:0] metaT;                    // metadata table, 8 flag bits

  // query selector, low two bits of the selector byte
  typedef logic [1:0] selectorT;

  localparam selectorT selValue = 2'd0;         // value, bit = nonzero
  localparam selectorT selMeta  = 2'd1;         // metadata, bit = nonzero
  localparam selectorT selEqual = 2'd2;         // value, bit = value matches new byte
  localparam selectorT selMask  = 2'd3;         // value & meta, bit = nonzero

  // ------------------------------------------------------------------------
  // request layout
  // ------------------------------------------------------------------------
  localparam int ctrlMutate = 0;                // control bit: write request
  localparam int ctrlMeta   = 1;                // control bit: target metadata table

  // field offsets inside inputData
  localparam int indexLsb    = 0;
  localparam int valueLsb    = 8;
  localparam int metaLsb     = 16;
  localparam int selectorLsb = 24;

endpackage

// ==== entryStore.sv ====
// indexed entry table, one synchronous write port and a combinational read port

`timescale 1ns/1ns

module entryStore #(
  parameter type payloadT = logic [7:0]         // entry payload
) (
  input  logic                             masterClock,
  input  logic                             writeEnable,  // store writeEntry at the edge
  input  logic [sandboxPkg::indexWidth-1:0] index,       // shared read / write index
  input  payloadT                          writeEntry,
  output payloadT                          readEntry     // entry at index, no latency
);

  import sandboxPkg::*;

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------
  // contents are undefined until written, the host writes before it reads
  payloadT entries [tableDepth];

  // one write per cycle at most
  always_ff @(posedge masterClock)
  begin
    if (writeEnable)
    begin
      entries[index] <= writeEntry;
    end
  end

  // --------------------------------------------------------------------------
  // read side
  // --------------------------------------------------------------------------
  // combinational, so the combiner sees the entry in the cycle the index is held
  assign readEntry = entries[index];

endmodule

// ==== resultCombiner.sv ====
// result combiner, folds a value / metadata pair into a result bit and byte per selector

`timescale 1ns/1ns

module resultCombiner (
  input  logic                 masterClock,
  input  logic                 reset,       // sync, active low
  input  sandboxPkg::valueT    valueEntry,  // value table entry at the request index
  input  sandboxPkg::metaT     metaEntry,   // metadata table entry, same index
  input  sandboxPkg::valueT    newValue,    // request's new-value byte
  input  sandboxPkg::selectorT selector,
  output logic                 resultBit,
  output sandboxPkg::valueT    resultByte
);

  import sandboxPkg::*;

  // --------------------------------------------------------------------------
  // selector decode
  // --------------------------------------------------------------------------
  logic  nextBit;
  valueT nextByte;
  valueT maskedByte;                            // value gated by metadata flags

  assign maskedByte = valueEntry & metaEntry;

  always_comb
  begin
    case (selector)
      selValue :
        begin
          nextByte = valueEntry;
          nextBit  = |valueEntry;               // any bit set
        end
      selMeta :
        begin
          nextByte = metaEntry;
          nextBit  = |metaEntry;
        end
      selEqual :
        begin
          nextByte = valueEntry;
          nextBit  = (valueEntry == newValue);  // compare against request byte
        end
      default :                                 // selMask, the last code
        begin
          nextByte = maskedByte;
          nextBit  = |maskedByte;
        end
    endcase
  end

  // --------------------------------------------------------------------------
  // result register, one cycle of latency
  // --------------------------------------------------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      resultBit  <= 1'b0;
      resultByte <= '0;
    end
    else
    begin
      resultBit  <= nextBit;                    // loaded every cycle
      resultByte <= nextByte;
    end
  end

endmodule

// ==== sandboxProcess.sv ====
// sandbox process, request decode and host handshake plus the one-blink-per-request indicator

`timescale 1ns/1ns

module sandboxProcess (
  input  logic                                masterClock,
  input  logic                                slowClock,     // indicator timing, sampled as a level
  input  logic                                reset,         // sync, active low
  input  logic                                dataReceived,  // host has a request waiting
  input  logic [sandboxPkg::ctrlWidth-1:0]    control,
  input  logic [sandboxPkg::dataWidth-1:0]    inputData,
  input  logic                                resultBit,     // from combiner
  input  sandboxPkg::valueT                   resultByte,
  output logic [sandboxPkg::indexWidth-1:0]   reqIndex,
  output sandboxPkg::valueT                   reqValue,
  output sandboxPkg::metaT                    reqMeta,
  output sandboxPkg::selectorT                reqSelector,
  output logic                                valueWrite,    // value table strobe
  output logic                                metaWrite,     // metadata table strobe
  output logic                                clearDR,       // request consumed, host may drop
  output logic                                transmitData,  // reply ready to send
  output logic [sandboxPkg::statusWidth-1:0]  status,
  output logic [sandboxPkg::dataWidth-1:0]    outputData,
  output logic                                rxIndicator    // one blink per request
);

  import sandboxPkg::*;

  typedef enum logic [2:0] {
    stIdle,       // waiting for dataReceived
    stExecute,    // table write / combiner load
    stReply,      // load reply, raise transmitData
    stSettle,     // spacer before clearDR
    stRelease     // raise clearDR, hold until host lets go
  } reqStateT;

  typedef enum logic [2:0] {
    indIdle,
    indWaitHigh,  // slowClock must be seen high first
    indWaitLow,   // falling transition lights the indicator
    indHoldHigh,
    indWaitFall   // next falling transition clears it
  } indStateT;

  reqStateT reqState;
  indStateT indState;

  logic   isMutate;                             // captured control bits
  logic   isMeta;
  valueT  indexByte;                            // full index byte, kept for the echo
  logic   startRequest;
  valueT  replyByte;
  logic [statusWidth-1:0] replyStatus;

  // --------------------------------------------------------------------------
  // decode and strobes
  // --------------------------------------------------------------------------
  assign startRequest = (reqState == stIdle) && dataReceived;
  assign reqIndex     = indexByte[indexWidth-1:0];  // upper index bits ignored

  // exactly one strobe, only in execute
  assign valueWrite = (reqState == stExecute) && isMutate && !isMeta;
  assign metaWrite  = (reqState == stExecute) && isMutate && isMeta;

  // mutation replies carry fixed status and a zero result byte
  assign replyByte   = isMutate ? valueT'(0) : resultByte;
  assign replyStatus = isMutate ? statusWidth'(2'b11) : statusWidth'(resultBit);

  // request fields, payload only
  always_ff @(posedge masterClock)
  begin
    if (startRequest)
    begin
      indexByte   <= inputData[indexLsb +: 8];
      reqValue    <= inputData[valueLsb +: 8];
      reqMeta     <= inputData[metaLsb +: 8];
      reqSelector <= inputData[selectorLsb +: $bits(selectorT)];  // bits 31:26 dropped
    end
  end

  // --------------------------------------------------------------------------
  // request machine
  // --------------------------------------------------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      reqState     <= stIdle;
      isMutate     <= 1'b0;
      isMeta       <= 1'b0;
      transmitData <= 1'b0;
      clearDR      <= 1'b0;
      status       <= '0;
      outputData   <= '0;
    end
    else
    begin
      case (reqState)
        stIdle :
          begin
            if (dataReceived)                   // edge E
            begin
              isMutate <= control[ctrlMutate];
              isMeta   <= control[ctrlMeta];
              reqState <= stExecute;
            end
          end
        stExecute :
          begin
            reqState <= stReply;                // write lands, combiner loads
          end
        stReply :
          begin
            status       <= replyStatus;
            outputData   <= {replyByte, reqMeta, reqValue, indexByte};  // echo low 24
            transmitData <= 1'b1;
            reqState     <= stSettle;
          end
        stSettle :
          begin
            reqState <= stRelease;
          end
        stRelease :
          begin
            if (!clearDR)
            begin
              clearDR <= 1'b1;                  // E+4
            end
            else if (!dataReceived)             // host let go, drop handshake
            begin
              transmitData <= 1'b0;
              clearDR      <= 1'b0;
              reqState     <= stIdle;
            end
          end
        default :
          begin
            reqState <= stIdle;
          end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // user indicator
  // --------------------------------------------------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      indState    <= indIdle;
      rxIndicator <= 1'b0;
    end
    else
    begin
      case (indState)
        indIdle :
          begin
            if (startRequest)                   // busy blink ignores new requests
            begin
              indState <= indWaitHigh;
            end
          end
        indWaitHigh :
          begin
            if (slowClock)
            begin
              indState <= indWaitLow;
            end
          end
        indWaitLow :
          begin
            if (!slowClock)
            begin
              rxIndicator <= 1'b1;
              indState    <= indHoldHigh;
            end
          end
        indHoldHigh :
          begin
            if (slowClock)
            begin
              indState <= indWaitFall;
            end
          end
        indWaitFall :
          begin
            if (!slowClock)
            begin
              rxIndicator <= 1'b0;
              indState    <= indIdle;
            end
          end
        default :
          begin
            indState    <= indIdle;
            rxIndicator <= 1'b0;
          end
      endcase
    end
  end

endmodule

// ==== sandboxTop.sv ====
// sandbox top, request process with value table, metadata table and result combiner

`timescale 1ns/1ns

module sandboxTop (
  input  logic                               masterClock,
  input  logic                               slowClock,
  input  logic                               reset,         // sync, active low
  input  logic                               dataReceived,
  input  logic [sandboxPkg::ctrlWidth-1:0]   control,
  input  logic [sandboxPkg::dataWidth-1:0]   inputData,
  output logic                               clearDR,
  output logic                               transmitData,
  output logic [sandboxPkg::statusWidth-1:0] status,
  output logic [sandboxPkg::dataWidth-1:0]   outputData,
  output logic                               rxIndicator
);

  import sandboxPkg::*;

  // --------------------------------------------------------------------------
  // internal nets
  // --------------------------------------------------------------------------
  logic [indexWidth-1:0] reqIndex;
  valueT                 reqValue;
  metaT                  reqMeta;
  selectorT              reqSelector;
  logic                  valueWrite;
  logic                  metaWrite;
  valueT                 valueEntry;            // combinational reads at reqIndex
  metaT                  metaEntry;
  logic                  resultBit;
  valueT                 resultByte;

  sandboxProcess sandboxProcess_inst (
    .masterClock  (masterClock),
    .slowClock    (slowClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .resultBit    (resultBit),
    .resultByte   (resultByte),
    .reqIndex     (reqIndex),
    .reqValue     (reqValue),
    .reqMeta      (reqMeta),
    .reqSelector  (reqSelector),
    .valueWrite   (valueWrite),
    .metaWrite    (metaWrite),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData),
    .rxIndicator  (rxIndicator)
  );

  // two tables, same index, separate strobes
  entryStore #(.payloadT(valueT)) valueStore (
    .masterClock (masterClock),
    .writeEnable (valueWrite),
    .index       (reqIndex),
    .writeEntry  (reqValue),
    .readEntry   (valueEntry)
  );

  entryStore #(.payloadT(metaT)) metaStore (
    .masterClock (masterClock),
    .writeEnable (metaWrite),
    .index       (reqIndex),
    .writeEntry  (reqMeta),
    .readEntry   (metaEntry)
  );

  resultCombiner resultCombiner_inst (
    .masterClock (masterClock),
    .reset       (reset),
    .valueEntry  (valueEntry),
    .metaEntry   (metaEntry),
    .newValue    (reqValue),                    // compare operand for selEqual
    .selector    (reqSelector),
    .resultBit   (resultBit),
    .resultByte  (resultByte)
  );

endmodule

// ==== sandboxTb.sv ====
// sandbox testbench, drives host requests, models both tables and checks every reply

`timescale 1ns/1ns

module sandboxTb;

  import sandboxPkg::*;

  // ------------------------------------------------------------------------
  // run length
  // ------------------------------------------------------------------------
  localparam int randomWrites    = 20;          // per table
  localparam int equalPairs      = 4;           // selEqual true / false pairs
  localparam int overrideSteps   = 5;
  localparam int requestTotal    = 4 * tableDepth + 2 * randomWrites + 2 * equalPairs
                                   + tableDepth + overrideSteps;
  localparam int cycleLimit      = 40 * requestTotal + 100;

  logic        masterClock;
  logic        slowClock    = 1'b0;
  logic        reset        = 1'b0;             // held low from time zero
  logic        dataReceived = 1'b0;
  logic [7:0]  control      = 8'h00;
  logic [31:0] inputData    = 32'h0;
  logic        clearDR;
  logic        transmitData;
  logic [7:0]  status;
  logic [31:0] outputData;
  logic        rxIndicator;

  logic [2:0]  divCount   = 3'd0;               // slowClock divider, 8 cycles
  logic [31:0] lfsrState  = 32'h4ffd;
  int          cycleCount = 0;
  logic [7:0]  expStatus  = 8'h00;              // expected reply, set per request
  logic [31:0] expData    = 32'h0;
  valueT       valueModel [tableDepth];
  metaT        metaModel  [tableDepth];

  // request tracking, phase counts edges since E
  logic [2:0]  phase     = 3'd0;
  int          reqCount  = 0;
  int          riseCount = 0;                   // rxIndicator rising edges seen
  logic        prevInd   = 1'b0;
  logic        prevSlow  = 1'b0;
  logic        prevSlow2 = 1'b0;

  sandboxTop sandboxTop_inst (
    .masterClock  (masterClock),
    .slowClock    (slowClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData),
    .rxIndicator  (rxIndicator)
  );

  initial
  begin
    masterClock = 1'b0;
    forever #10 masterClock = ~masterClock;     // 20 ns period
  end

  always @(posedge masterClock)
  begin
    divCount  <= divCount + 3'd1;
    slowClock <= divCount[2];                   // 160 ns period
  end

  // ------------------------------------------------------------------------
  // failure reporting
  // ------------------------------------------------------------------------
  task automatic abortRun();
    $display("TEST FAILED");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] want,
                                input logic [31:0] got);
    $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, want, got);
    abortRun();
  endtask

  always @(posedge masterClock)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      abortRun();
    end
  end

  // ------------------------------------------------------------------------
  // handshake and indicator tracking
  // ------------------------------------------------------------------------
  always @(posedge masterClock)
  begin
    if (!reset)
    begin
      phase     <= 3'd0;
      reqCount  <= 0;
      riseCount <= 0;
      prevInd   <= 1'b0;
      prevSlow  <= 1'b0;
      prevSlow2 <= 1'b0;
    end
    else
    begin
      prevInd   <= rxIndicator;
      prevSlow  <= slowClock;
      prevSlow2 <= prevSlow;
      if (rxIndicator && !prevInd)
      begin
        riseCount <= riseCount + 1;
      end
      if (phase == 3'd0)
      begin
        if (dataReceived)                       // edge E
        begin
          phase    <= 3'd1;
          reqCount <= reqCount + 1;
        end
      end
      else if (phase < 3'd5)
      begin
        phase <= phase + 3'd1;
      end
      else if (!dataReceived)                   // host let go
      begin
        phase <= 3'd0;
      end
    end
  end

  // transmitData from E+2, clearDR from E+4, both until release
  assert property (@(posedge masterClock) disable iff (!reset)
    transmitData == (phase >= 3'd3))
    else reportMismatch("transmitData", 32'($sampled(phase >= 3'd3)),
                        32'($sampled(transmitData)));

  assert property (@(posedge masterClock) disable iff (!reset)
    clearDR == (phase == 3'd5))
    else reportMismatch("clearDR", 32'($sampled(phase == 3'd5)), 32'($sampled(clearDR)));

  // reply held for the whole transmit window, zero before any request
  assert property (@(posedge masterClock) disable iff (!reset)
    (reqCount == 0 || phase >= 3'd3) |-> status == expStatus)
    else reportMismatch("status", 32'($sampled(expStatus)), 32'($sampled(status)));

  assert property (@(posedge masterClock) disable iff (!reset)
    (reqCount == 0 || phase >= 3'd3) |-> outputData == expData)
    else reportMismatch("outputData", $sampled(expData), $sampled(outputData));

  assert property (@(posedge masterClock) disable iff (!reset)
    reqCount == 0 |-> !rxIndicator)
    else reportMismatch("rxIndicator", 32'h0, 32'($sampled(rxIndicator)));

  // any indicator change follows a high then low slowClock sample
  assert property (@(posedge masterClock) disable iff (!reset)
    (rxIndicator != prevInd) |-> (prevSlow2 && !prevSlow))
    else reportMismatch("slowClock before rxIndicator edge", 32'h2,
                        32'($sampled({prevSlow2, prevSlow})));

  assert property (@(posedge masterClock) disable iff (!reset)
    riseCount <= reqCount)
    else reportMismatch("rxIndicator pulses", 32'($sampled(reqCount)),
                        32'($sampled(riseCount)));

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic feedback;
    feedback = s[31] ^ s[21] ^ s[1] ^ s[0];     // taps 32 22 2 1
    return {s[30:0], feedback};
  endfunction

  task automatic drawBits(input int count, output logic [31:0] bits);
    bits = 32'h0;
    for (int k = 0; k < count; k++)
    begin
      lfsrState = lfsrNext(lfsrState);
      bits      = {bits[30:0], lfsrState[0]};   // one step per bit
    end
  endtask

  // expected {bit, byte} from the table model
  function automatic logic [8:0] queryResult(input selectorT sel,
                                             input logic [indexWidth-1:0] idx,
                                             input valueT newVal);
    valueT v;
    metaT  m;
    v = valueModel[idx];
    m = metaModel[idx];
    case (sel)
      selValue : return {v != 8'h00, v};
      selMeta  : return {m != 8'h00, m};
      selEqual : return {v == newVal, v};
      default  : return {(v & m) != 8'h00, v & m};
    endcase
  endfunction

  // one full request, returns once the handshake and the blink are over
  task automatic sendRequest(input logic [7:0] ctrl, input logic [31:0] data,
                             input logic [7:0] wantStatus, input logic [31:0] wantData);
    logic [31:0] holdBits;
    drawBits(3, holdBits);
    @(posedge masterClock);
    control      <= ctrl;
    inputData    <= data;
    dataReceived <= 1'b1;
    @(posedge masterClock);                     // edge E
    expStatus    <= wantStatus;                 // new reply expected from here on
    expData      <= wantData;
    while (!clearDR)
    begin
      @(posedge masterClock);
    end
    repeat (holdBits[2:0]) @(posedge masterClock);   // random back-pressure
    dataReceived <= 1'b0;
    @(posedge masterClock);
    while (transmitData || rxIndicator || riseCount != reqCount)
    begin
      @(posedge masterClock);
    end
  endtask

  task automatic doWrite(input logic toMeta, input valueT indexByte, input valueT entry);
    logic [31:0] noise;
    logic [31:0] data;
    drawBits(22, noise);
    if (toMeta)
    begin
      data = {noise[7:0], entry, noise[15:8], indexByte};
      metaModel[indexByte[indexWidth-1:0]] = entry;
    end
    else
    begin
      data = {noise[7:0], noise[15:8], entry, indexByte};
      valueModel[indexByte[indexWidth-1:0]] = entry;
    end
    sendRequest({noise[21:16], toMeta, 1'b1}, data, 8'h03, {8'h00, data[23:0]});
  endtask

  task automatic doQuery(input selectorT sel, input valueT indexByte, input valueT newVal);
    logic [31:0] noise;
    logic [31:0] data;
    logic [8:0]  result;
    drawBits(21, noise);
    data   = {noise[5:0], sel, noise[13:6], newVal, indexByte};  // junk above selector
    result = queryResult(sel, indexByte[indexWidth-1:0], newVal);
    sendRequest({noise[20:14], 1'b0}, data, {7'b0, result[8]}, {result[7:0], data[23:0]});
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial
  begin
    int          i;
    logic [31:0] r;
    valueT       stored;
    repeat (3) @(posedge masterClock);
    reset <= 1'b1;
    repeat (4) @(posedge masterClock);          // idle outputs checked here
    for (i = 0; i < tableDepth; i++)            // every index defined first
    begin
      doWrite(1'b0, valueT'(i), valueT'(i * 37 + 5));
      doWrite(1'b1, valueT'(i), metaT'(i * 11 + 90));
    end
    for (i = 0; i < randomWrites; i++)
    begin
      drawBits(16, r);
      doWrite(1'b0, r[7:0], r[15:8]);
      drawBits(16, r);
      doWrite(1'b1, r[7:0], r[15:8]);
    end
    for (i = 0; i < tableDepth; i++)            // readback, upper index bits random
    begin
      drawBits(16, r);
      doQuery(selValue, {r[3:0], 4'(i)}, r[15:8]);
      doQuery(selMeta, {r[7:4], 4'(i)}, r[15:8]);
    end
    for (i = 0; i < equalPairs; i++)
    begin
      drawBits(8, r);
      stored = valueModel[r[indexWidth-1:0]];
      doQuery(selEqual, r[7:0], stored);
      doQuery(selEqual, r[7:0], stored ^ 8'h5c);
    end
    for (i = 0; i < tableDepth; i++)
    begin
      drawBits(12, r);
      doQuery(selMask, {r[3:0], 4'(i)}, r[11:4]);
    end
    drawBits(24, r);                            // same index written twice
    doWrite(1'b0, r[7:0], r[15:8]);
    doWrite(1'b0, r[7:0], r[23:16]);
    doQuery(selMask, r[7:0], 8'h00);
    doWrite(1'b0, r[7:0], 8'h00);
    doQuery(selValue, r[7:0], 8'h00);           // zero value, result bit clear
    repeat (2) @(posedge masterClock);
    if (reqCount == requestTotal && riseCount == reqCount)
    begin
      $display("TEST OK");
      $finish;
    end
    else
    begin
      $display("wrong count: %0d requests, %0d indicator pulses", reqCount, riseCount);
      abortRun();
    end
  end

endmodule

// ==== sim.f ====
sandboxPkg.sv
entryStore.sv
resultCombiner.sv
sandboxProcess.sv
sandboxTop.sv
sandboxTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the sandbox testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module sandboxTb -f sim.f

output=$(./obj_dir/VsandboxTb 2>&1) || true
echo "$output"

# pass only when the testbench printed its pass line
echo "$output" | grep -qx "TEST OK"
